/* gpio_loop_top.f */
source/gpio_pkg.sv
source/rate_strobe_gen.sv
source/gpio_port.sv
source/ext_device.sv
source/gpio_driver.sv
source/gpio_loop_top.sv
test/tb_gpio_loop_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds the loopback testbench with Verilator and runs it.
# The exit status is the simulator's, nonzero on any failure.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
	--top-module tb_gpio_loop_top \
	--Mdir obj_dir \
	-f gpio_loop_top.f
./obj_dir/Vtb_gpio_loop_top

/* test/tb_gpio_loop_top.sv */
// Testbench for the GPIO loopback subsystem.
// Inputs change 1 ns after each rising edge and outputs are sampled at the same point.
// Expected reads come from a queue model of the device FIFO, which drops
// writes once it holds queue_depth words and answers zero with empty set.
// The turnaround check probes side_read inside the DUT by hierarchical name.
// The run stops at the first mismatch.

`timescale 1ns/1ps
`default_nettype none

module tb_gpio_loop_top;
	import gpio_pkg::*;

	localparam int random_cmds = 300;
	localparam int cycles_per_cmd = 40;
	localparam int timeout_cycles = random_cmds * cycles_per_cmd;

	logic ck_ref;
	logic rst;
	logic cmd_valid;
	host_cmd_t cmd;
	logic busy;
	logic rsp_valid;
	host_rsp_t rsp;
	logic pad_oe_seen;

	logic [31:0] rng_state;
	gpio_word_t model_q[$];
	int cycle_count = 0;

	gpio_loop_top gpio_loop_top_inst (
		.ck_ref(ck_ref),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.busy(busy),
		.rsp_valid(rsp_valid),
		.rsp(rsp),
		.pad_oe_seen(pad_oe_seen)
	);

	always #2 ck_ref = ~ck_ref;

	// Hard limit on the whole run
	always @(posedge ck_ref) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Run did not finish within %0d cycles", timeout_cycles);
			abort_run();
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_random(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	task automatic next_cycle();
		@(posedge ck_ref);
		#1;
	endtask

	task automatic abort_run();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_value(input string test_name, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s %s: expected %h, actual %h", test_name, field,
				expected, actual);
			abort_run();
		end
	endtask

	// Issues one command, waits for its end and compares it with the model.
	// With inject set, extra commands are pulsed while busy is high.
	task automatic run_cmd(input string test_name, input logic op, input gpio_word_t data,
		input logic inject);
		logic [31:0] r;
		host_rsp_t got;
		gpio_word_t exp_data;
		logic exp_empty;
		logic done;
		logic read_started;
		logic data_seen;
		int gap_cycles;
		int wait_cycles;

		got = '0;
		done = 1'b0;
		read_started = 1'b0;
		data_seen = 1'b0;
		gap_cycles = 0;
		wait_cycles = 0;
		check_value(test_name, "busy before command", 32'd0, 32'(busy));
		cmd_valid = 1'b1;
		cmd.op = op;
		cmd.data = data;
		next_cycle();
		cmd_valid = 1'b0;
		check_value(test_name, "busy after accept", 32'd1, 32'(busy));

		while (!done) begin
			if (op) begin
				check_value(test_name, "rsp_valid during write", 32'd0, 32'(rsp_valid));
				done = !busy;
			end else begin
				// The port has let go of the pads, so nothing drives before side_read
				if (!read_started) begin
					check_value(test_name, "pads idle before side_read", 32'd0,
						32'(pad_oe_seen));
				end else if (pad_oe_seen) begin
					data_seen = 1'b1;
				end else if (!data_seen) begin
					gap_cycles++;
				end
				if (gpio_loop_top_inst.side_read) begin
					read_started = 1'b1;
				end
				if (rsp_valid) begin
					done = 1'b1;
					got = rsp;
					check_value(test_name, "busy with rsp_valid", 32'd0, 32'(busy));
				end
			end
			if (!done) begin
				if (wait_cycles >= cycles_per_cmd) begin
					$display("%s: command not finished after %0d cycles", test_name,
						cycles_per_cmd);
					abort_run();
				end else begin
					next_random(r);
					if (inject && busy && r[2:0] == 3'd0) begin
						cmd_valid = 1'b1;
						cmd.op = r[3];
						cmd.data = r[31:16];
					end
					next_cycle();
					cmd_valid = 1'b0;
					wait_cycles++;
				end
			end
		end

		if (op) begin
			if (model_q.size() < queue_depth) begin
				model_q.push_back(data);
			end
		end else begin
			if (model_q.size() == 0) begin
				exp_empty = 1'b1;
				exp_data = '0;
			end else begin
				exp_empty = 1'b0;
				exp_data = model_q.pop_front();
			end
			check_value(test_name, "read empty flag", 32'(exp_empty), 32'(got.empty));
			check_value(test_name, "read data", 32'(exp_data), 32'(got.data));
			check_value(test_name, "side_read seen", 32'd1, 32'(read_started));
			check_value(test_name, "device drove pads", 32'd1, 32'(data_seen));
			check_value(test_name, "idle pad cycle after side_read", 32'd1,
				32'(gap_cycles > 0));
		end
	endtask

	initial begin
		logic [31:0] r;
		ck_ref = 1'b0;
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		rng_state = 32'd58073;
		repeat (3) @(posedge ck_ref);
		#1;
		rst = 1'b0;

		check_value("reset", "busy", 32'd0, 32'(busy));
		check_value("reset", "rsp_valid", 32'd0, 32'(rsp_valid));
		check_value("reset", "pad_oe_seen", 32'd0, 32'(pad_oe_seen));
		next_cycle();

		next_random(r);
		run_cmd("write_read", 1'b1, r[31:16], 1'b0);
		run_cmd("write_read", 1'b0, '0, 1'b0);

		run_cmd("empty_read", 1'b0, '0, 1'b0);

		// The last two of these ten writes find the eight-deep FIFO full
		for (int i = 0; i < 10; i++) begin
			next_random(r);
			run_cmd("order_overflow", 1'b1, r[31:16], 1'b0);
		end
		for (int i = 0; i < 10; i++) begin
			run_cmd("order_overflow", 1'b0, '0, 1'b0);
		end

		for (int i = 0; i < random_cmds; i++) begin
			next_random(r);
			run_cmd("random_mix", r[7], r[31:16], 1'b1);
		end

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* source/gpio_loop_top.sv */
// Loopback subsystem top level on a single clock, ck_ref.
// The pad bus takes whichever side has its output enable high and reads
// as zero when neither drives. pad_oe_seen shows the turnaround gap.
// Only one command is in flight; the host must watch busy.

`timescale 1ns/1ps
`default_nettype none

module gpio_loop_top (
	input  logic                ck_ref,
	input  logic                rst,
	input  logic                cmd_valid,
	input  gpio_pkg::host_cmd_t cmd,
	output logic                busy,
	output logic                rsp_valid,
	output gpio_pkg::host_rsp_t rsp,
	output logic                pad_oe_seen
);
	import gpio_pkg::*;

	gpio_word_t tx_word;
	gpio_word_t rx_word;
	pad_beat_t port_beat;
	pad_beat_t dev_beat;
	pad_beat_t pad_bus;
	logic fr_tick;
	logic tx_load;
	logic dir_out;
	logic side_write;
	logic side_read;
	logic port_oe;
	logic rx_done;
	logic dev_oe;
	logic dev_empty;

	assign pad_bus = port_oe ? port_beat : (dev_oe ? dev_beat : '0);
	assign pad_oe_seen = port_oe | dev_oe;

	// Bursts start on any full-rate tick, so the frame strobe stays open
	rate_strobe_gen rate_strobe_gen_inst (
		.ck_ref(ck_ref),
		.rst(rst),
		.fr_tick(fr_tick),
		.hr_tick()
	);

	gpio_driver gpio_driver_inst (
		.ck_ref(ck_ref),
		.rst(rst),
		.fr_tick(fr_tick),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.busy(busy),
		.tx_word(tx_word),
		.tx_load(tx_load),
		.dir_out(dir_out),
		.side_write(side_write),
		.side_read(side_read),
		.rx_word(rx_word),
		.rx_done(rx_done),
		.dev_empty(dev_empty),
		.rsp_valid(rsp_valid),
		.rsp(rsp)
	);

	gpio_port gpio_port_inst (
		.ck_ref(ck_ref),
		.rst(rst),
		.fr_tick(fr_tick),
		.tx_word(tx_word),
		.tx_load(tx_load),
		.dir_out(dir_out),
		.pad_in(pad_bus),
		.port_beat(port_beat),
		.port_oe(port_oe),
		.rx_word(rx_word),
		.rx_done(rx_done)
	);

	ext_device ext_device_inst (
		.ck_ref(ck_ref),
		.rst(rst),
		.fr_tick(fr_tick),
		.side_write(side_write),
		.side_read(side_read),
		.pad_in(pad_bus),
		.dev_beat(dev_beat),
		.dev_oe(dev_oe),
		.dev_empty(dev_empty)
	);

endmodule

`default_nettype wire

/* source/gpio_driver.sv */
// Command sequencer for the loopback path.
// A command is taken when cmd_valid is high and busy is low; anything
// arriving while busy is ignored, with no back-pressure.
// dir_out rests high so a read always begins with a falling edge.
// Side strobes are combinational and aligned to fr_tick.

`timescale 1ns/1ps
`default_nettype none

module gpio_driver (
	input  logic                 ck_ref,
	input  logic                 rst,
	input  logic                 fr_tick,
	input  logic                 cmd_valid,
	input  gpio_pkg::host_cmd_t  cmd,
	output logic                 busy,
	output gpio_pkg::gpio_word_t tx_word,
	output logic                 tx_load,
	output logic                 dir_out,
	output logic                 side_write,
	output logic                 side_read,
	input  gpio_pkg::gpio_word_t rx_word,
	input  logic                 rx_done,
	input  logic                 dev_empty,
	output logic                 rsp_valid,
	output gpio_pkg::host_rsp_t  rsp
);
	import gpio_pkg::*;

	burst_state_t state;
	beat_index_t cnt;
	logic accept;
	logic wr_armed;
	logic empty_q;

	assign accept = cmd_valid && !busy;

	// The first write beat leaves the port on the same tick as side_write,
	// so the strobe waits until the word has been loaded
	assign side_write = (state == write_burst) && fr_tick && !wr_armed && !tx_load;
	assign side_read = (state == turnaround) && fr_tick;

	always_ff @(posedge ck_ref) begin
		if (rst) begin
			state <= idle;
			cnt <= '0;
			busy <= 1'b0;
			tx_load <= 1'b0;
			dir_out <= 1'b1;
			wr_armed <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			tx_load <= 1'b0;
			rsp_valid <= 1'b0;
			case (state)
				idle: begin
					if (accept) begin
						busy <= 1'b1;
						if (cmd.op) begin
							state <= write_burst;
							tx_load <= 1'b1;
							dir_out <= 1'b1;
						end else begin
							state <= turnaround;
							dir_out <= 1'b0;
						end
					end
				end
				write_burst: begin
					if (side_write) begin
						wr_armed <= 1'b1;
						cnt <= '0;
					end else if (fr_tick && wr_armed) begin
						// Done once the device has sampled the last beat
						if (cnt == last_beat) begin
							state <= idle;
							busy <= 1'b0;
							wr_armed <= 1'b0;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				turnaround: begin
					if (side_read) begin
						state <= read_burst;
					end
				end
				read_burst: begin
					if (rx_done) begin
						state <= idle;
						busy <= 1'b0;
						rsp_valid <= 1'b1;
						dir_out <= 1'b1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge ck_ref) begin
		if (accept && cmd.op) begin
			tx_word <= cmd.data;
		end
		if (side_read) begin
			empty_q <= dev_empty;
		end
		if (state == read_burst && rx_done) begin
			rsp.empty <= empty_q;
			rsp.data <= rx_word;
		end
	end

	// The port only finishes a capture while a read burst waits for it
	a_rx_done_in_read: assert property (
		@(posedge ck_ref) disable iff (rst)
		rx_done |-> state == read_burst
	) else $error("rx_done arrived outside a read burst");

endmodule

`default_nettype wire

/* source/ext_device.sv */
// Far-side device model on the pads.
// A write burst starts with side_write and is sampled on the next four
// fr_ticks; the word is pushed into a queue_depth FIFO or dropped when full.
// A read burst starts with side_read, skips one turnaround tick and then
// drives the oldest word, or zero when empty, for four beats.
// dev_empty is only meaningful in the side_read cycle.

`timescale 1ns/1ps
`default_nettype none

module ext_device (
	input  logic                ck_ref,
	input  logic                rst,
	input  logic                fr_tick,
	input  logic                side_write,
	input  logic                side_read,
	input  gpio_pkg::pad_beat_t pad_in,
	output gpio_pkg::pad_beat_t dev_beat,
	output logic                dev_oe,
	output logic                dev_empty
);
	import gpio_pkg::*;

	gpio_word_t mem [queue_depth];
	gpio_word_t cap_shift;
	gpio_word_t cap_word;
	gpio_word_t rd_shift;
	queue_ptr_t wr_ptr;
	queue_ptr_t rd_ptr;
	queue_count_t count;
	beat_index_t cnt;
	burst_state_t state;
	logic full;
	logic push;
	logic pop;
	logic launch;

	assign dev_empty = (count == '0);
	assign full = (count == queue_full);
	assign cap_word = {pad_in, cap_shift[word_w-1:pin_count]};
	assign push = (state == write_burst) && fr_tick && (cnt == last_beat) && !full;
	assign pop = side_read && !dev_empty;
	assign launch = (state == read_burst) && fr_tick && !(dev_oe && cnt == last_beat);

	always_ff @(posedge ck_ref) begin
		if (rst) begin
			state <= idle;
			cnt <= '0;
			dev_oe <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// Push and pop belong to different bursts and never coincide
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
				count <= count + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
				count <= count - 1'b1;
			end

			case (state)
				idle: begin
					if (side_write) begin
						state <= write_burst;
						cnt <= '0;
					end else if (side_read) begin
						state <= turnaround;
					end
				end
				write_burst: begin
					if (fr_tick) begin
						if (cnt == last_beat) begin
							state <= idle;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				turnaround: begin
					if (fr_tick) begin
						state <= read_burst;
						cnt <= '0;
					end
				end
				read_burst: begin
					if (launch) begin
						dev_oe <= 1'b1;
						if (dev_oe) begin
							cnt <= cnt + 1'b1;
						end
					end else if (fr_tick) begin
						dev_oe <= 1'b0;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge ck_ref) begin
		if (state == write_burst && fr_tick) begin
			cap_shift <= cap_word;
		end
		if (push) begin
			mem[wr_ptr] <= cap_word;
		end
		if (side_read) begin
			rd_shift <= dev_empty ? '0 : mem[rd_ptr];
		end else if (launch) begin
			dev_beat <= rd_shift[pin_count-1:0];
			rd_shift <= rd_shift >> pin_count;
		end
	end

	// A new burst may only begin once the device has released the pads,
	// which keeps port and device from driving at the same time
	a_burst_from_idle: assert property (
		@(posedge ck_ref) disable iff (rst)
		(side_write || side_read) |-> state == idle
	) else $error("Burst started while the device was still busy");

	// A push and a pop together would lose one update of the occupancy count
	a_push_pop_apart: assert property (
		@(posedge ck_ref) disable iff (rst)
		!(push && pop)
	) else $error("FIFO push and pop in the same cycle");

endmodule

`default_nettype wire

/* source/gpio_port.sv */
// GPIO port between half-rate words and full-rate pad beats.
// A loaded word leaves least significant nibble first, one beat per fr_tick,
// only while dir_out is high. port_oe follows the beats it launches.
// Capture begins rx_skip ticks after dir_out falls and takes beats_per_word
// beats; dir_out must stay low until rx_done. One outgoing word can be held
// while a capture is in progress.

`timescale 1ns/1ps
`default_nettype none

module gpio_port (
	input  logic                 ck_ref,
	input  logic                 rst,
	input  logic                 fr_tick,
	input  gpio_pkg::gpio_word_t tx_word,
	input  logic                 tx_load,
	input  logic                 dir_out,
	input  gpio_pkg::pad_beat_t  pad_in,
	output gpio_pkg::pad_beat_t  port_beat,
	output logic                 port_oe,
	output gpio_pkg::gpio_word_t rx_word,
	output logic                 rx_done
);
	import gpio_pkg::*;

	gpio_word_t tx_shift;
	gpio_word_t rx_shift;
	beat_index_t tx_cnt;
	rx_phase_t rx_phase;
	logic tx_busy;
	logic launch;
	logic capture;

	assign launch = fr_tick && tx_busy && dir_out && !tx_load;
	assign capture = fr_tick && !dir_out && (rx_phase >= rx_first) &&
		(rx_phase <= rx_last);
	assign rx_word = rx_shift;

	// Output side
	always_ff @(posedge ck_ref) begin
		if (rst) begin
			tx_busy <= 1'b0;
			tx_cnt <= '0;
			port_oe <= 1'b0;
		end else begin
			if (tx_load) begin
				tx_busy <= 1'b1;
				tx_cnt <= '0;
			end else if (launch) begin
				port_oe <= 1'b1;
				if (tx_cnt == last_beat) begin
					tx_busy <= 1'b0;
				end else begin
					tx_cnt <= tx_cnt + 1'b1;
				end
			end else if (fr_tick) begin
				// The last beat stays on the pads for one full-rate period
				port_oe <= 1'b0;
			end
		end
	end

	always_ff @(posedge ck_ref) begin
		if (tx_load) begin
			tx_shift <= tx_word;
		end else if (launch) begin
			port_beat <= tx_shift[pin_count-1:0];
			tx_shift <= tx_shift >> pin_count;
		end
	end

	// Input side
	// The phase counter restarts whenever the port owns the pads again
	always_ff @(posedge ck_ref) begin
		if (rst) begin
			rx_phase <= '0;
			rx_done <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			if (dir_out) begin
				rx_phase <= '0;
			end else if (fr_tick && rx_phase <= rx_last) begin
				rx_phase <= rx_phase + 1'b1;
				if (rx_phase == rx_last) begin
					rx_done <= 1'b1;
				end
			end
		end
	end

	// New beats enter at the top, so beat 0 ends up in the low nibble
	always_ff @(posedge ck_ref) begin
		if (capture) begin
			rx_shift <= {pad_in, rx_shift[word_w-1:pin_count]};
		end
	end

	// The driver may only load a word once the previous one has left
	a_no_load_while_shifting: assert property (
		@(posedge ck_ref) disable iff (rst)
		tx_load |-> !tx_busy
	) else $error("tx_load while a word is still being shifted out");

endmodule

`default_nettype wire

/* source/rate_strobe_gen.sv */
// Full-rate and half-rate enable strobes in the ck_ref domain.
// Both strobes are single-cycle and registered; hr_tick coincides with
// every beats_per_word-th fr_tick. No derived clocks are produced.

`timescale 1ns/1ps
`default_nettype none

module rate_strobe_gen (
	input  logic ck_ref,
	input  logic rst,
	output logic fr_tick,
	output logic hr_tick
);
	import gpio_pkg::*;

	div_count_t div_cnt;
	beat_index_t beat_cnt;

	always_ff @(posedge ck_ref) begin
		if (rst) begin
			div_cnt <= '0;
			beat_cnt <= '0;
			fr_tick <= 1'b0;
			hr_tick <= 1'b0;
		end else begin
			fr_tick <= 1'b0;
			hr_tick <= 1'b0;
			if (div_cnt == div_last) begin
				div_cnt <= '0;
				fr_tick <= 1'b1;
				// Frame strobe rides on the last beat slot of each word
				hr_tick <= (beat_cnt == last_beat);
				beat_cnt <= beat_cnt + 1'b1;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* source/gpio_pkg.sv */
// Shared constants and types for the GPIO loopback subsystem.
// One fixed configuration: bidirectional, 4 pins, 4 beats per word.
// Beat 0 of a word is its least significant nibble.
// queue_depth must be a power of two so the device pointers wrap freely.

`default_nettype none

package gpio_pkg;

	localparam int pin_count = 4;
	localparam int beats_per_word = 4;
	localparam int queue_depth = 8;
	localparam int fr_divide = 2;

	localparam int word_w = pin_count * beats_per_word;
	localparam int beat_w = $clog2(beats_per_word);
	localparam int div_w = $clog2(fr_divide);
	localparam int queue_w = $clog2(queue_depth);

	// Full-rate ticks with dir_out low before the port samples its first beat
	// are the side_read tick, the turnaround tick and the device launch tick
	localparam int rx_skip = 3;
	localparam int rx_phase_w = $clog2(rx_skip + beats_per_word + 1);

	typedef logic [pin_count-1:0] pad_beat_t;
	typedef logic [word_w-1:0] gpio_word_t;
	typedef logic [beat_w-1:0] beat_index_t;
	typedef logic [div_w-1:0] div_count_t;
	typedef logic [queue_w-1:0] queue_ptr_t;
	typedef logic [queue_w:0] queue_count_t;
	typedef logic [rx_phase_w-1:0] rx_phase_t;

	localparam beat_index_t last_beat = beat_index_t'(beats_per_word - 1);
	localparam div_count_t div_last = div_count_t'(fr_divide - 1);
	localparam queue_count_t queue_full = queue_count_t'(queue_depth);
	localparam rx_phase_t rx_first = rx_phase_t'(rx_skip);
	localparam rx_phase_t rx_last = rx_phase_t'(rx_skip + beats_per_word - 1);

	// op is 1 for a write, 0 for a read
	typedef struct packed {
		logic op;
		gpio_word_t data;
	} host_cmd_t;

	typedef struct packed {
		logic empty;
		gpio_word_t data;
	} host_rsp_t;

	typedef enum logic [1:0] {
		idle,
		write_burst,
		turnaround,
		read_burst
	} burst_state_t;

endpackage

`default_nettype wire
